// File: verilog/afe_pkg.sv
// sample and bus types, converter format functions, bus regions, register map and id
`default_nettype none

package afe_pkg;

  // --------------------
  // widths and types
  localparam int ADC_W      = 14;                    // adc and dac sample width
  localparam int REGION_LSB = 20;                    // region field is addr[22:20]
  localparam int OFS_W      = 20;                    // offset field inside a region

  typedef logic signed [ADC_W-1:0] sample_t;         // two's complement sample
  typedef logic        [ADC_W-1:0] raw_sample_t;     // converter pin format
  typedef logic        [31:0]      bus_word_t;       // bus data
  typedef logic        [31:0]      bus_addr_t;       // bus address
  typedef logic        [2:0]       region_t;         // 8 regions
  typedef logic        [OFS_W-1:0] offset_t;         // in-region offset

  localparam sample_t     SAMPLE_MAX = 14'sh1fff;    // +8191
  localparam sample_t     SAMPLE_MIN = 14'sh2000;    // -8192, also peak clear value
  localparam raw_sample_t DAC_ZERO   = 14'h1fff;     // dac code of 0

  // --------------------
  // bus map
  localparam region_t REGION_CTRL = 3'd0;            // control registers
  localparam region_t REGION_ADC  = 3'd1;            // adc capture

  localparam offset_t REG_ID     = 20'h00;           // read only
  localparam offset_t REG_LED    = 20'h04;
  localparam offset_t REG_STEP_A = 20'h08;
  localparam offset_t REG_STEP_B = 20'h0c;
  localparam offset_t REG_OFS_A  = 20'h10;
  localparam offset_t REG_OFS_B  = 20'h14;
  localparam offset_t REG_GEN_EN = 20'h18;           // bit 0 = a, bit 1 = b

  localparam offset_t CAP_LAST_A = 20'h00;
  localparam offset_t CAP_LAST_B = 20'h04;
  localparam offset_t CAP_PEAK_A = 20'h08;           // clear on read
  localparam offset_t CAP_PEAK_B = 20'h0c;           // clear on read

  localparam bus_word_t AFE_ID = 32'h4146_0001;

  // --------------------
  // converter formats
  // negative slope offset binary: msb kept, other bits inverted, in both directions
  function automatic sample_t adc_to_sample(input raw_sample_t raw);
    return {raw[ADC_W-1], ~raw[ADC_W-2:0]};
  endfunction

  function automatic raw_sample_t sample_to_dac(input sample_t s);
    return {s[ADC_W-1], ~s[ADC_W-2:0]};
  endfunction

  function automatic bus_word_t sext_word(input sample_t s);
    return {{($bits(bus_word_t)-ADC_W){s[ADC_W-1]}}, s};  // sign extend for readback
  endfunction

endpackage

`default_nettype wire

// File: verilog/sys_bus_decoder.sv
// system bus decoder: region strobes, pending region, unmapped answer, response mux
`timescale 1ns/100ps
`default_nettype none

module sys_bus_decoder import afe_pkg::*; (
  input  wire logic      adc_clk,
  input  wire logic      rst_i,
  input  wire bus_addr_t sys_addr_i,
  input  wire logic      sys_wen_i,
  input  wire logic      sys_ren_i,
  output      logic      ctrl_wen_o,                // region 0 strobes
  output      logic      ctrl_ren_o,
  output      logic      cap_wen_o,                 // region 1 strobes
  output      logic      cap_ren_o,
  input  wire bus_word_t ctrl_rdata_i,
  input  wire logic      ctrl_ack_i,
  input  wire logic      ctrl_err_i,
  input  wire bus_word_t cap_rdata_i,
  input  wire logic      cap_ack_i,
  input  wire logic      cap_err_i,
  output      bus_word_t sys_rdata_o,
  output      logic      sys_ack_o,
  output      logic      sys_err_o
);

  region_t region;                                  // region of current address
  region_t region_q;                                // region of pending access
  logic    strobe;
  logic    unmapped_q;                              // own answer for regions 2..7

  assign region = sys_addr_i[REGION_LSB +: $bits(region_t)];
  assign strobe = sys_wen_i | sys_ren_i;

  // strobe only reaches the addressed slave
  assign ctrl_wen_o = sys_wen_i & (region == REGION_CTRL);
  assign ctrl_ren_o = sys_ren_i & (region == REGION_CTRL);
  assign cap_wen_o  = sys_wen_i & (region == REGION_ADC);
  assign cap_ren_o  = sys_ren_i & (region == REGION_ADC);

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      region_q   <= REGION_CTRL;
      unmapped_q <= 1'b0;
    end else begin
      if (strobe) begin
        region_q <= region;                         // held until next access
      end
      unmapped_q <= strobe && (region != REGION_CTRL) && (region != REGION_ADC);
    end
  end

  // --------------------
  // response mux, picked by pending region
  always_comb begin
    case (region_q)
      REGION_CTRL: begin
        sys_rdata_o = ctrl_rdata_i;
        sys_ack_o   = ctrl_ack_i;
        sys_err_o   = ctrl_err_i;
      end
      REGION_ADC: begin
        sys_rdata_o = cap_rdata_i;
        sys_ack_o   = cap_ack_i;
        sys_err_o   = cap_err_i;
      end
      default: begin
        sys_rdata_o = '0;                           // nothing mapped here
        sys_ack_o   = unmapped_q;
        sys_err_o   = unmapped_q;
      end
    endcase
  end

  a_one_strobe: assert property (@(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i));

  // every slave and the unmapped path answer exactly one cycle later
  a_ack_next: assert property (@(posedge adc_clk) disable iff (rst_i)
    strobe |=> sys_ack_o);

endmodule

`default_nettype wire

// File: verilog/afe_ctrl_regs.sv
// region 0 control and status registers: id, leds, generator steps and enables, dac offsets
`timescale 1ns/100ps
`default_nettype none

module afe_ctrl_regs import afe_pkg::*; #(
  parameter int PHASE_W = 24
) (
  input  wire logic         adc_clk,
  input  wire logic         rst_i,
  input  wire bus_addr_t    addr_i,
  input  wire bus_word_t    wdata_i,
  input  wire logic         wen_i,
  input  wire logic         ren_i,
  output      bus_word_t    rdata_o,
  output      logic         ack_o,
  output      logic         err_o,
  output logic [PHASE_W-1:0] step_a_o,              // phase step ch a
  output logic [PHASE_W-1:0] step_b_o,              // phase step ch b
  output      sample_t      ofs_a_o,                // dac offset ch a
  output      sample_t      ofs_b_o,                // dac offset ch b
  output      logic [1:0]   gen_en_o,               // generator enables
  output      logic [7:0]   led_o
);

  offset_t   ofs;                                   // in-region offset
  bus_word_t rd_val;
  logic      rd_ok;                                 // offset readable
  logic      wr_ok;                                 // offset writable

  assign ofs = addr_i[OFS_W-1:0];

  // --------------------
  // offset decode
  always_comb begin
    rd_ok  = 1'b1;
    wr_ok  = 1'b1;
    rd_val = '0;
    case (ofs)
      REG_ID: begin
        rd_val = AFE_ID;
        wr_ok  = 1'b0;                              // id is read only
      end
      REG_LED:    rd_val = bus_word_t'(led_o);
      REG_STEP_A: rd_val = bus_word_t'(step_a_o);   // zero extended
      REG_STEP_B: rd_val = bus_word_t'(step_b_o);
      REG_OFS_A:  rd_val = sext_word(ofs_a_o);
      REG_OFS_B:  rd_val = sext_word(ofs_b_o);
      REG_GEN_EN: rd_val = bus_word_t'(gen_en_o);
      default: begin
        rd_ok = 1'b0;                               // unknown offset
        wr_ok = 1'b0;
      end
    endcase
  end

  // --------------------
  // register writes and handshake
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      led_o    <= '0;
      step_a_o <= '0;
      step_b_o <= '0;
      ofs_a_o  <= '0;
      ofs_b_o  <= '0;
      gen_en_o <= '0;                               // generators stopped
    end else begin
      ack_o <= wen_i | ren_i;
      err_o <= (wen_i & ~wr_ok) | (ren_i & ~rd_ok);
      if (wen_i) begin
        case (ofs)
          REG_LED:    led_o    <= wdata_i[7:0];
          REG_STEP_A: step_a_o <= PHASE_W'(wdata_i);
          REG_STEP_B: step_b_o <= PHASE_W'(wdata_i);
          REG_OFS_A:  ofs_a_o  <= wdata_i[ADC_W-1:0];
          REG_OFS_B:  ofs_b_o  <= wdata_i[ADC_W-1:0];
          REG_GEN_EN: gen_en_o <= wdata_i[1:0];
          default:    ;                             // id and holes answered with err
        endcase
      end
    end
  end

  // read data is zero on writes and errors
  always_ff @(posedge adc_clk) begin
    rdata_o <= (ren_i && rd_ok) ? rd_val : '0;
  end

endmodule

`default_nettype wire

// File: verilog/adc_capture.sv
// adc format conversion, region 1 last sample and clear-on-read peak registers
`timescale 1ns/100ps
`default_nettype none

module adc_capture import afe_pkg::*; (
  input  wire logic        adc_clk,
  input  wire logic        rst_i,
  input  wire raw_sample_t adc_dat_a_i,
  input  wire raw_sample_t adc_dat_b_i,
  input  wire bus_addr_t   addr_i,
  input  wire logic        wen_i,
  input  wire logic        ren_i,
  output      sample_t     adc_a_o,                 // converted, 1 cycle late
  output      sample_t     adc_b_o,
  output      bus_word_t   rdata_o,
  output      logic        ack_o,
  output      logic        err_o
);

  sample_t   conv   [2];                            // converted inputs
  sample_t   last_q [2];
  sample_t   peak_q [2];                            // running signed max
  logic [1:0] peak_clr;                             // read of own peak address
  bus_word_t rd_val;
  logic      rd_ok;

  assign conv[0] = adc_to_sample(adc_dat_a_i);
  assign conv[1] = adc_to_sample(adc_dat_b_i);
  assign adc_a_o = last_q[0];
  assign adc_b_o = last_q[1];

  assign peak_clr[0] = ren_i && (addr_i[OFS_W-1:0] == CAP_PEAK_A);
  assign peak_clr[1] = ren_i && (addr_i[OFS_W-1:0] == CAP_PEAK_B);

  // --------------------
  // sample and peak tracking
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      last_q[ch] <= conv[ch];
    end
  end

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      if (rst_i || peak_clr[ch]) begin
        peak_q[ch] <= SAMPLE_MIN;                   // lowest value, next sample wins
      end else if (conv[ch] > peak_q[ch]) begin
        peak_q[ch] <= conv[ch];
      end
    end
  end

  // --------------------
  // bus side
  always_comb begin
    rd_ok  = 1'b1;
    rd_val = '0;
    case (addr_i[OFS_W-1:0])
      CAP_LAST_A: rd_val = sext_word(last_q[0]);
      CAP_LAST_B: rd_val = sext_word(last_q[1]);
      CAP_PEAK_A: rd_val = sext_word(peak_q[0]);    // value before the clear
      CAP_PEAK_B: rd_val = sext_word(peak_q[1]);
      default:    rd_ok  = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= wen_i | ren_i;
      err_o <= wen_i | (ren_i & ~rd_ok);            // region is read only
    end
  end

  always_ff @(posedge adc_clk) begin
    rdata_o <= (ren_i && rd_ok) ? rd_val : '0;
  end

endmodule

`default_nettype wire

// File: verilog/saw_gen.sv
// two channel phase accumulator sawtooth generator
`timescale 1ns/100ps
`default_nettype none

module saw_gen import afe_pkg::*; #(
  parameter int PHASE_W = 24                        // 14 or more
) (
  input  wire logic               adc_clk,
  input  wire logic               rst_i,
  input  wire logic [PHASE_W-1:0] step_a_i,
  input  wire logic [PHASE_W-1:0] step_b_i,
  input  wire logic [1:0]         gen_en_i,         // bit 0 = a, bit 1 = b
  output      sample_t            saw_a_o,
  output      sample_t            saw_b_o
);

  logic [PHASE_W-1:0] step  [2];
  logic [PHASE_W-1:0] acc_q [2];                    // phase, wraps freely

  assign step[0] = step_a_i;
  assign step[1] = step_b_i;

  // --------------------
  // accumulators
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      acc_q[0] <= '0;
      acc_q[1] <= '0;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        if (gen_en_i[ch]) begin
          acc_q[ch] <= acc_q[ch] + step[ch];        // modulo 2^PHASE_W
        end else begin
          acc_q[ch] <= '0;                          // held at zero while off
        end
      end
    end
  end

  // top bits of phase, read as signed
  assign saw_a_o = acc_q[0][PHASE_W-1 -: ADC_W];
  assign saw_b_o = acc_q[1][PHASE_W-1 -: ADC_W];

endmodule

`default_nettype wire

// File: verilog/dac_mixer.sv
// dac mixer: sawtooth plus offset, 14 bit saturation, dac format output register
`timescale 1ns/100ps
`default_nettype none

module dac_mixer import afe_pkg::*; (
  input  wire logic        adc_clk,
  input  wire logic        rst_i,
  input  wire sample_t     saw_a_i,
  input  wire sample_t     saw_b_i,
  input  wire sample_t     ofs_a_i,
  input  wire sample_t     ofs_b_i,
  output      raw_sample_t dac_dat_a_o,
  output      raw_sample_t dac_dat_b_o
);

  sample_t               saw   [2];
  sample_t               ofs   [2];
  logic signed [ADC_W:0] sum   [2];                 // one guard bit
  raw_sample_t           dac_q [2];

  // top two sum bits 01 = positive overflow, 10 = negative overflow
  function automatic sample_t sat(input logic signed [ADC_W:0] s);
    case (s[ADC_W -: 2])
      2'b01:   return SAMPLE_MAX;
      2'b10:   return SAMPLE_MIN;
      default: return s[ADC_W-1:0];
    endcase
  endfunction

  assign saw[0] = saw_a_i;
  assign saw[1] = saw_b_i;
  assign ofs[0] = ofs_a_i;
  assign ofs[1] = ofs_b_i;

  assign sum[0] = saw[0] + ofs[0];                  // sign extended before add
  assign sum[1] = saw[1] + ofs[1];

  // --------------------
  // output register
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      dac_q[0] <= DAC_ZERO;
      dac_q[1] <= DAC_ZERO;
    end else begin
      for (int ch = 0; ch < 2; ch++) begin
        dac_q[ch] <= sample_to_dac(sat(sum[ch]));
      end
    end
  end

  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

  // clamped value stays in range, so the dac msb keeps the sign of the true sum
  for (genvar ch = 0; ch < 2; ch++) begin : g_chk
    a_sat_sign: assert property (@(posedge adc_clk) disable iff (rst_i)
      !rst_i |=> dac_q[ch][ADC_W-1] == $past(sum[ch][ADC_W]));
  end

endmodule

`default_nettype wire

// File: verilog/afe_top.sv
// two channel analog front end top: bus decoder, registers, capture, sawtooth, dac mixer
`timescale 1ns/100ps
`default_nettype none

module afe_top import afe_pkg::*; #(
  parameter int PHASE_W = 24                        // accumulator width, 14 or more
) (
  input  wire logic        adc_clk,
  input  wire logic        rst_i,                   // sync, active high
  input  wire raw_sample_t adc_dat_a_i,             // adc ch a, raw
  input  wire raw_sample_t adc_dat_b_i,             // adc ch b, raw
  input  wire bus_addr_t   sys_addr_i,
  input  wire bus_word_t   sys_wdata_i,
  input  wire logic        sys_wen_i,               // one cycle write strobe
  input  wire logic        sys_ren_i,               // one cycle read strobe
  output      bus_word_t   sys_rdata_o,
  output      logic        sys_ack_o,               // one cycle after strobe
  output      logic        sys_err_o,
  output      raw_sample_t dac_dat_a_o,             // dac ch a, raw
  output      raw_sample_t dac_dat_b_o,             // dac ch b, raw
  output      logic [7:0]  led_o
);

  // --------------------
  // bus fabric
  logic      ctrl_wen, ctrl_ren, ctrl_ack, ctrl_err;
  logic      cap_wen, cap_ren, cap_ack, cap_err;
  bus_word_t ctrl_rdata, cap_rdata;

  // steering from control regs
  logic [PHASE_W-1:0] step_a, step_b;
  sample_t            ofs_a, ofs_b;
  logic [1:0]         gen_en;

  sample_t saw_a, saw_b;                            // generator samples

  sys_bus_decoder i_sys_bus_decoder (
    .adc_clk      (adc_clk),
    .rst_i        (rst_i),
    .sys_addr_i   (sys_addr_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .ctrl_wen_o   (ctrl_wen),
    .ctrl_ren_o   (ctrl_ren),
    .cap_wen_o    (cap_wen),
    .cap_ren_o    (cap_ren),
    .ctrl_rdata_i (ctrl_rdata),
    .ctrl_ack_i   (ctrl_ack),
    .ctrl_err_i   (ctrl_err),
    .cap_rdata_i  (cap_rdata),
    .cap_ack_i    (cap_ack),
    .cap_err_i    (cap_err),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o)
  );

  afe_ctrl_regs #(.PHASE_W(PHASE_W)) i_afe_ctrl_regs (
    .adc_clk   (adc_clk),
    .rst_i     (rst_i),
    .addr_i    (sys_addr_i),
    .wdata_i   (sys_wdata_i),
    .wen_i     (ctrl_wen),
    .ren_i     (ctrl_ren),
    .rdata_o   (ctrl_rdata),
    .ack_o     (ctrl_ack),
    .err_o     (ctrl_err),
    .step_a_o  (step_a),
    .step_b_o  (step_b),
    .ofs_a_o   (ofs_a),
    .ofs_b_o   (ofs_b),
    .gen_en_o  (gen_en),
    .led_o     (led_o)
  );

  adc_capture i_adc_capture (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .addr_i      (sys_addr_i),
    .wen_i       (cap_wen),
    .ren_i       (cap_ren),
    .adc_a_o     (),                                // no user logic on the adc samples yet
    .adc_b_o     (),
    .rdata_o     (cap_rdata),
    .ack_o       (cap_ack),
    .err_o       (cap_err)
  );

  // --------------------
  // dac path
  saw_gen #(.PHASE_W(PHASE_W)) i_saw_gen (
    .adc_clk  (adc_clk),
    .rst_i    (rst_i),
    .step_a_i (step_a),
    .step_b_i (step_b),
    .gen_en_i (gen_en),
    .saw_a_o  (saw_a),
    .saw_b_o  (saw_b)
  );

  dac_mixer i_dac_mixer (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .saw_a_i     (saw_a),
    .saw_b_i     (saw_b),
    .ofs_a_i     (ofs_a),
    .ofs_b_i     (ofs_b),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

endmodule

`default_nettype wire

// File: test/tb_afe_tasks.svh
// bus access tasks, compare tasks and reference models for the front end testbench
`ifndef TB_AFE_TASKS_SVH
`define TB_AFE_TASKS_SVH

// --------------------
// reference models
// msb kept, lower 13 bits inverted
function automatic sample_t ref_adc(input raw_sample_t raw);
  return sample_t'(raw ^ 14'h1fff);
endfunction

function automatic raw_sample_t ref_dac(input sample_t s);
  return raw_sample_t'(s) ^ 14'h1fff;
endfunction

function automatic bus_word_t ref_sext(input sample_t s);
  return bus_word_t'(int'(s));                    // signed widen
endfunction

function automatic sample_t ref_sat(input int v);
  if (v > 8191) return 14'sd8191;
  if (v < -8192) return -14'sd8192;
  return sample_t'(v);
endfunction

function automatic bus_addr_t make_addr(input region_t r, input offset_t o);
  return {9'b0, r, o};                            // region on bits 22..20
endfunction

// --------------------
// compare tasks
task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
  if (got !== exp) begin
    $display("error %s: got %h, expected %h", name, got, exp);
    value_errors++;
  end
endtask

task automatic check_raw(input string name, input raw_sample_t got, input raw_sample_t exp);
  if (got !== exp) begin
    $display("error %s: got %h, expected %h", name, got, exp);
    value_errors++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error %s: got %h, expected %h", name, got, exp);
    value_errors++;
  end
endtask

// --------------------
// bus access, strobe for one cycle then wait for ack
task automatic bus_cycle(input logic wr, input bus_addr_t addr, input bus_word_t wdata,
                         output bus_word_t rdata, output logic err);
  int   waited;
  logic ack_seen;
  @(posedge adc_clk);
  #IN_DLY;
  sys_addr_i  = addr;
  sys_wdata_i = wdata;
  sys_wen_i   = wr;
  sys_ren_i   = !wr;
  @(posedge adc_clk);
  #IN_DLY;
  sys_wen_i = 1'b0;
  sys_ren_i = 1'b0;
  waited    = 1;
  ack_seen  = sys_ack_o;
  check_flag("sys_ack_o one cycle after strobe", ack_seen, 1'b1);
  while (!ack_seen && waited < ACK_TIMEOUT) begin
    @(posedge adc_clk);
    #IN_DLY;
    waited++;
    ack_seen = sys_ack_o;
  end
  if (!ack_seen) begin
    $display("no ack for address %h within %0d cycles", addr, ACK_TIMEOUT);
    other_errors++;
  end
  rdata = sys_rdata_o;                            // registered, stable here
  err   = sys_err_o;
endtask

task automatic bus_write(input bus_addr_t addr, input bus_word_t wdata, output logic err);
  bus_word_t rdata;
  bus_cycle(1'b1, addr, wdata, rdata, err);
  check_word("sys_rdata_o on write", rdata, '0);
endtask

task automatic bus_read(input bus_addr_t addr, output bus_word_t rdata, output logic err);
  bus_cycle(1'b0, addr, '0, rdata, err);
endtask

`endif

// File: test/tb_afe_top.sv
// front end testbench: clock, reset, DUT instance, directed tests and closing error report
`timescale 1ns/100ps
`default_nettype none

module tb_afe_top import afe_pkg::*;;

  localparam int PHASE_W     = 24;
  localparam int CLK_HALF    = 50;                // 100 ns period
  localparam int IN_DLY      = 10;                // drive point after rising edge
  localparam int ACK_TIMEOUT = 16;
  localparam int SAT_CYCLES  = 40;

  logic        adc_clk;
  logic        rst_i;
  raw_sample_t adc_dat_a_i;
  raw_sample_t adc_dat_b_i;
  bus_addr_t   sys_addr_i;
  bus_word_t   sys_wdata_i;
  logic        sys_wen_i;
  logic        sys_ren_i;
  bus_word_t   sys_rdata_o;
  logic        sys_ack_o;
  logic        sys_err_o;
  raw_sample_t dac_dat_a_o;
  raw_sample_t dac_dat_b_o;
  logic [7:0]  led_o;

  int value_errors;
  int other_errors;

  always #CLK_HALF adc_clk = ~adc_clk;

  afe_top #(.PHASE_W(PHASE_W)) i_afe_top (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o),
    .led_o       (led_o)
  );

  `include "tb_afe_tasks.svh"

  // --------------------
  // small bus helpers
  task automatic write_ok(input bus_addr_t addr, input bus_word_t w);
    logic err;
    bus_write(addr, w, err);
    check_flag("sys_err_o on write", err, 1'b0);
  endtask

  task automatic read_expect(input bus_addr_t addr, input bus_word_t exp, input string name);
    bus_word_t rd;
    logic      err;
    bus_read(addr, rd, err);
    check_flag("sys_err_o on read", err, 1'b0);
    check_word(name, rd, exp);
  endtask

  task automatic access_expect_err(input bus_addr_t addr);
    bus_word_t rd;
    logic      err;
    bus_write(addr, $urandom, err);               // rdata zero checked inside
    check_flag("sys_err_o on bad write", err, 1'b1);
    bus_read(addr, rd, err);
    check_flag("sys_err_o on bad read", err, 1'b1);
    check_word("sys_rdata_o on bad read", rd, '0);
  endtask

  // --------------------
  // directed tests
  task automatic test_reset_id();
    check_flag("sys_ack_o after reset", sys_ack_o, 1'b0);
    check_flag("sys_err_o after reset", sys_err_o, 1'b0);
    check_word("led_o after reset", bus_word_t'(led_o), '0);
    check_raw("dac_dat_a_o after reset", dac_dat_a_o, 14'h1fff);   // code of zero
    check_raw("dac_dat_b_o after reset", dac_dat_b_o, 14'h1fff);
    read_expect(make_addr(REGION_CTRL, REG_ID), AFE_ID, "sys_rdata_o id");
  endtask

  task automatic test_register_access();
    bus_word_t w;
    bus_word_t step_mask;
    logic      err;
    step_mask = bus_word_t'({PHASE_W{1'b1}});
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_LED), w);
    read_expect(make_addr(REGION_CTRL, REG_LED), w & 32'hff, "sys_rdata_o led");
    check_word("led_o", bus_word_t'(led_o), w & 32'hff);
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_STEP_A), w);
    read_expect(make_addr(REGION_CTRL, REG_STEP_A), w & step_mask, "sys_rdata_o step a");
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_STEP_B), w);
    read_expect(make_addr(REGION_CTRL, REG_STEP_B), w & step_mask, "sys_rdata_o step b");
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_OFS_A), w);
    read_expect(make_addr(REGION_CTRL, REG_OFS_A), ref_sext(sample_t'(w)), "sys_rdata_o ofs a");
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_OFS_B), w);
    read_expect(make_addr(REGION_CTRL, REG_OFS_B), ref_sext(sample_t'(w)), "sys_rdata_o ofs b");
    w = $urandom;
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), w);
    read_expect(make_addr(REGION_CTRL, REG_GEN_EN), w & 32'h3, "sys_rdata_o gen en");
    bus_write(make_addr(REGION_CTRL, REG_ID), $urandom, err);       // read only
    check_flag("sys_err_o on id write", err, 1'b1);
    read_expect(make_addr(REGION_CTRL, REG_ID), AFE_ID, "sys_rdata_o id after write");
    access_expect_err(make_addr(REGION_CTRL, 20'h1c));             // hole after gen en
    for (int r = 2; r < 8; r++) begin
      access_expect_err(make_addr(region_t'(r), offset_t'($urandom)));
    end
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), '0);                // generators off
  endtask

  task automatic test_adc_capture();
    raw_sample_t ra;
    raw_sample_t rb;
    sample_t     max_a;
    sample_t     max_b;
    bus_word_t   rd;
    logic        err;
    @(posedge adc_clk);
    #IN_DLY;
    ra = raw_sample_t'($urandom);
    rb = raw_sample_t'($urandom);
    adc_dat_a_i = ra;
    adc_dat_b_i = rb;
    read_expect(make_addr(REGION_ADC, CAP_LAST_A), ref_sext(ref_adc(ra)), "sys_rdata_o last a");
    read_expect(make_addr(REGION_ADC, CAP_LAST_B), ref_sext(ref_adc(rb)), "sys_rdata_o last b");
    bus_read(make_addr(REGION_ADC, CAP_PEAK_A), rd, err);          // clears peak a
    bus_read(make_addr(REGION_ADC, CAP_PEAK_B), rd, err);
    max_a = ref_adc(ra);                                            // held through the clear
    max_b = ref_adc(rb);
    repeat (24) begin
      @(posedge adc_clk);
      #IN_DLY;
      ra = raw_sample_t'($urandom);
      rb = raw_sample_t'($urandom);
      adc_dat_a_i = ra;
      adc_dat_b_i = rb;
      if (ref_adc(ra) > max_a) max_a = ref_adc(ra);
      if (ref_adc(rb) > max_b) max_b = ref_adc(rb);
    end
    read_expect(make_addr(REGION_ADC, CAP_PEAK_A), ref_sext(max_a), "sys_rdata_o peak a");
    read_expect(make_addr(REGION_ADC, CAP_PEAK_B), ref_sext(max_b), "sys_rdata_o peak b");
    // after the clear only the held sample is seen
    read_expect(make_addr(REGION_ADC, CAP_PEAK_A), ref_sext(ref_adc(ra)), "sys_rdata_o peak a 2");
    read_expect(make_addr(REGION_ADC, CAP_PEAK_B), ref_sext(ref_adc(rb)), "sys_rdata_o peak b 2");
  endtask

  task automatic test_offset_path();
    sample_t oa;
    sample_t ob;
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), '0);
    repeat (6) begin
      oa = sample_t'($urandom);
      ob = sample_t'($urandom);
      write_ok(make_addr(REGION_CTRL, REG_OFS_A), ref_sext(oa));
      write_ok(make_addr(REGION_CTRL, REG_OFS_B), ref_sext(ob));
      @(posedge adc_clk);                                           // mixer register
      #IN_DLY;
      check_raw("dac_dat_a_o", dac_dat_a_o, ref_dac(oa));
      check_raw("dac_dat_b_o", dac_dat_b_o, ref_dac(ob));
    end
  endtask

  task automatic saturation_run(input sample_t ofs);
    raw_sample_t lo;
    raw_sample_t hi;
    logic [3:0]  seen;                                              // a lo, a hi, b lo, b hi
    lo   = ref_dac(ref_sat(int'(ofs)));                             // sawtooth at 0
    hi   = ref_dac(ref_sat(int'(ofs) - 8192));                      // sawtooth at -8192
    seen = '0;
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), '0);
    write_ok(make_addr(REGION_CTRL, REG_OFS_A), ref_sext(ofs));
    write_ok(make_addr(REGION_CTRL, REG_OFS_B), ref_sext(ofs));
    write_ok(make_addr(REGION_CTRL, REG_STEP_A), bus_word_t'(1) << (PHASE_W - 1));
    write_ok(make_addr(REGION_CTRL, REG_STEP_B), bus_word_t'(1) << (PHASE_W - 1));
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), 32'h3);
    repeat (SAT_CYCLES) begin
      @(posedge adc_clk);
      #IN_DLY;
      if (dac_dat_a_o !== lo && dac_dat_a_o !== hi) check_raw("dac_dat_a_o", dac_dat_a_o, lo);
      if (dac_dat_b_o !== lo && dac_dat_b_o !== hi) check_raw("dac_dat_b_o", dac_dat_b_o, lo);
      seen |= {dac_dat_b_o === hi, dac_dat_b_o === lo, dac_dat_a_o === hi, dac_dat_a_o === lo};
    end
    check_flag("dac_dat_a_o both levels seen", &seen[1:0], 1'b1);
    check_flag("dac_dat_b_o both levels seen", &seen[3:2], 1'b1);
  endtask

  task automatic test_saturation();
    saturation_run(-14'sd1);
    saturation_run(14'sd8191);
    write_ok(make_addr(REGION_CTRL, REG_GEN_EN), '0);
  endtask

  // --------------------
  // sequence
  initial begin
    adc_clk      = 1'b0;
    rst_i        = 1'b1;
    adc_dat_a_i  = '0;
    adc_dat_b_i  = '0;
    sys_addr_i   = '0;
    sys_wdata_i  = '0;
    sys_wen_i    = 1'b0;
    sys_ren_i    = 1'b0;
    value_errors = 0;
    other_errors = 0;
    void'($urandom(32'h235c));
    repeat (4) @(posedge adc_clk);
    #IN_DLY;
    rst_i = 1'b0;
    test_reset_id();
    test_register_access();
    test_adc_capture();
    test_offset_path();
    test_saturation();
    $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+test
verilog/afe_pkg.sv
verilog/sys_bus_decoder.sv
verilog/afe_ctrl_regs.sv
verilog/adc_capture.sv
verilog/saw_gen.sv
verilog/dac_mixer.sv
verilog/afe_top.sv
test/tb_afe_top.sv

// File: run_sim.sh
#!/bin/sh
# build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_afe_top --Mdir obj_dir -o sim_afe
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_afe)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
